//--- logic/rv_alu.sv
// Branch compare uses the sign of the difference so BLT and BGE misjudge on signed overflow
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
  input  logic [`RV_ALU_W-1:0] alu_op,
  input  logic [31:0]          alu_in_1,
  input  logic [31:0]          alu_in_2,
  input  logic [2:0]           funct3,
  output logic [31:0]          alu_result,
  output logic                 alu_bcond
);

  always_comb begin
    alu_result = 32'd0;
    alu_bcond  = 1'b0;
    case (alu_op)
      `RV_F3_ADD: alu_result = alu_in_1 + alu_in_2;
      `RV_ALU_SUB: begin
        alu_result = alu_in_1 - alu_in_2;
        // Branch test on the difference
        case (funct3)
          `RV_F3_BEQ: alu_bcond = (alu_result == 32'd0);
          `RV_F3_BNE: alu_bcond = (alu_result != 32'd0);
          `RV_F3_BLT: alu_bcond = alu_result[31];
          `RV_F3_BGE: alu_bcond = !alu_result[31];
          default:    alu_bcond = 1'b0;
        endcase
      end
      `RV_F3_SLL: alu_result = alu_in_1 << alu_in_2[4:0];
      `RV_F3_XOR: alu_result = alu_in_1 ^ alu_in_2;
      `RV_F3_OR:  alu_result = alu_in_1 | alu_in_2;
      `RV_F3_AND: alu_result = alu_in_1 & alu_in_2;
      `RV_F3_SRL: alu_result = alu_in_1 >> alu_in_2[4:0];  // Logical only
      default: begin
        alu_result = 32'd0;
      end
    endcase
  end

endmodule

//--- logic/rv_alu_ctrl.sv
// ALU operation select where SRA is treated as SUB on R-type and as SRL on I-type
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu_ctrl (
  input  rv_pkg::instr_t               instr,
  input  logic [`RV_ALUOP_W-1:0]       alu_op_class,
  output logic [`RV_ALU_W-1:0]         alu_op
);

  always_comb begin
    case (alu_op_class)
      `RV_ALUOP_ADD: alu_op = `RV_F3_ADD;
      `RV_ALUOP_SUB: alu_op = `RV_ALU_SUB;
      `RV_ALUOP_FUNCT: begin
        case (instr.r.opcode)
          `RV_OP_ARITH: begin
            if (instr.r.funct7 == `RV_F7_SUB) begin
              alu_op = `RV_ALU_SUB;
            end else begin
              alu_op = instr.r.funct3;
            end
          end
          `RV_OP_ARITH_IMM: alu_op = instr.i.funct3;  // funct7 bits belong to the immediate
          `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_JALR: begin
            alu_op = `RV_F3_ADD;
          end
          `RV_OP_BRANCH: alu_op = `RV_ALU_SUB;
          default: alu_op = `RV_F3_ADD;
        endcase
      end
      default: alu_op = `RV_F3_ADD;
    endcase
  end

endmodule

//--- logic/rv_consts.svh
// Encodings for the RV32I subset only and the multicycle control codes that go with them
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Major opcodes
`define RV_OP_ARITH      7'b0110011
`define RV_OP_ARITH_IMM  7'b0010011
`define RV_OP_LOAD       7'b0000011
`define RV_OP_STORE      7'b0100011
`define RV_OP_BRANCH     7'b1100011
`define RV_OP_JAL        7'b1101111
`define RV_OP_JALR       7'b1100111

`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101

`define RV_F7_SUB  7'b0100000

// Subtract sits on a funct3 slot the subset never decodes
`define RV_ALU_SUB  3'b010
`define RV_ALU_W    3

`define RV_ALUOP_ADD    2'b00
`define RV_ALUOP_SUB    2'b01
`define RV_ALUOP_FUNCT  2'b10
`define RV_ALUOP_W      2

`define RV_PC_SRC_PC4     2'b00
`define RV_PC_SRC_ALUOUT  2'b01  // Branch target from DECODE
`define RV_PC_SRC_JUMP    2'b10  // Jump target straight from the ALU
`define RV_PC_SRC_W       2

`define RV_ST_FETCH   3'd0
`define RV_ST_DECODE  3'd1
`define RV_ST_EXEC    3'd2
`define RV_ST_MEM     3'd3
`define RV_ST_WBACK   3'd4
`define RV_ST_W       3

`define RV_RESET_PC  32'h0000_0000

`endif

//--- logic/rv_core.sv
// Wishbone classic master for full-word accesses without sel err rty or bursts
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic        clk,
  input  logic        reset,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_wdata,
  input  logic [31:0] wb_rdata,
  input  logic        wb_ack
);

  rv_pkg::instr_t instr;
  logic alu_bcond;
  logic pc_write;
  logic ir_write;
  logic mdr_write;
  logic reg_write;
  logic a_b_write;
  logic alu_out_write;
  logic [`RV_PC_SRC_W-1:0] pc_src;
  logic alu_src_a;
  logic alu_src_b;
  logic wb_sel_mem;
  logic wb_sel_pc4;
  logic adr_sel_data;
  logic [`RV_ALUOP_W-1:0] alu_op_class;

  rv_ctrl_fsm i_ctrl_fsm (
    .clk(clk), .reset(reset),
    .instr(instr), .alu_bcond(alu_bcond), .wb_ack(wb_ack),
    .pc_write(pc_write), .ir_write(ir_write), .mdr_write(mdr_write),
    .reg_write(reg_write), .a_b_write(a_b_write), .alu_out_write(alu_out_write),
    .pc_src(pc_src), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
    .wb_sel_mem(wb_sel_mem), .wb_sel_pc4(wb_sel_pc4), .adr_sel_data(adr_sel_data),
    .alu_op_class(alu_op_class),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we)
  );

  // Bus address and write data come from the datapath
  rv_datapath i_datapath (
    .clk(clk), .reset(reset),
    .pc_write(pc_write), .ir_write(ir_write), .mdr_write(mdr_write),
    .reg_write(reg_write), .a_b_write(a_b_write), .alu_out_write(alu_out_write),
    .pc_src(pc_src), .alu_src_a(alu_src_a), .alu_src_b(alu_src_b),
    .wb_sel_mem(wb_sel_mem), .wb_sel_pc4(wb_sel_pc4), .adr_sel_data(adr_sel_data),
    .alu_op_class(alu_op_class),
    .wb_rdata(wb_rdata),
    .instr(instr), .alu_bcond(alu_bcond),
    .wb_adr(wb_adr), .wb_wdata(wb_wdata)
  );

endmodule

//--- logic/rv_ctrl_fsm.sv
// One bus access at a time and unknown opcodes fall through to the next PC after DECODE
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_ctrl_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  rv_pkg::instr_t          instr,
  input  logic                    alu_bcond,
  input  logic                    wb_ack,
  output logic                    pc_write,
  output logic                    ir_write,
  output logic                    mdr_write,
  output logic                    reg_write,
  output logic                    a_b_write,
  output logic                    alu_out_write,
  output logic [`RV_PC_SRC_W-1:0] pc_src,
  output logic                    alu_src_a,
  output logic                    alu_src_b,
  output logic                    wb_sel_mem,
  output logic                    wb_sel_pc4,
  output logic                    adr_sel_data,
  output logic [`RV_ALUOP_W-1:0]  alu_op_class,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we
);

  logic [`RV_ST_W-1:0] state;
  logic [`RV_ST_W-1:0] state_n;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jump;
  logic known_op;
  logic bus_next;

  assign is_load   = (instr.r.opcode == `RV_OP_LOAD);
  assign is_store  = (instr.r.opcode == `RV_OP_STORE);
  assign is_branch = (instr.r.opcode == `RV_OP_BRANCH);
  assign is_jump   = (instr.r.opcode == `RV_OP_JAL) || (instr.r.opcode == `RV_OP_JALR);
  assign known_op  = is_load || is_store || is_branch || is_jump ||
                     (instr.r.opcode == `RV_OP_ARITH) || (instr.r.opcode == `RV_OP_ARITH_IMM);

  always_comb begin
    state_n       = state;
    pc_write      = 1'b0;
    ir_write      = 1'b0;
    mdr_write     = 1'b0;
    reg_write     = 1'b0;
    a_b_write     = 1'b0;
    alu_out_write = 1'b0;
    pc_src        = `RV_PC_SRC_PC4;
    alu_src_a     = 1'b0;  // A register
    alu_src_b     = 1'b0;  // B register
    wb_sel_mem    = 1'b0;
    wb_sel_pc4    = 1'b0;
    adr_sel_data  = 1'b0;
    alu_op_class  = `RV_ALUOP_ADD;
    case (state)
      `RV_ST_FETCH: begin
        if (wb_cyc && wb_ack) begin
          ir_write = 1'b1;
          state_n  = `RV_ST_DECODE;
        end
      end
      `RV_ST_DECODE: begin
        a_b_write = 1'b1;
        if (is_branch) begin
          // Branch target PC+imm parked in alu_out
          alu_src_a     = 1'b1;
          alu_src_b     = 1'b1;
          alu_out_write = 1'b1;
        end else if (!is_jump) begin
          pc_write = 1'b1;
        end
        state_n = known_op ? `RV_ST_EXEC : `RV_ST_FETCH;
      end
      `RV_ST_EXEC: begin
        alu_out_write = 1'b1;
        state_n       = `RV_ST_WBACK;
        case (instr.r.opcode)
          `RV_OP_ARITH: alu_op_class = `RV_ALUOP_FUNCT;
          `RV_OP_ARITH_IMM: begin
            alu_src_b    = 1'b1;
            alu_op_class = `RV_ALUOP_FUNCT;
          end
          `RV_OP_LOAD, `RV_OP_STORE: begin
            alu_src_b = 1'b1;
            state_n   = `RV_ST_MEM;
          end
          `RV_OP_BRANCH: begin
            alu_out_write = 1'b0;  // Keep the target
            alu_op_class  = `RV_ALUOP_SUB;
            pc_write      = 1'b1;
            pc_src        = alu_bcond ? `RV_PC_SRC_ALUOUT : `RV_PC_SRC_PC4;
            state_n       = `RV_ST_FETCH;
          end
          default: begin
            // JAL adds to the PC and JALR to rs1
            alu_src_a  = (instr.r.opcode == `RV_OP_JAL);
            alu_src_b  = 1'b1;
            pc_write   = 1'b1;
            pc_src     = `RV_PC_SRC_JUMP;
            wb_sel_pc4 = 1'b1;  // Link value staged in alu_out
          end
        endcase
      end
      `RV_ST_MEM: begin
        adr_sel_data = 1'b1;
        if (wb_cyc && wb_ack) begin
          mdr_write = is_load;
          state_n   = is_load ? `RV_ST_WBACK : `RV_ST_FETCH;
        end
      end
      `RV_ST_WBACK: begin
        reg_write  = 1'b1;
        wb_sel_mem = is_load;
        state_n    = `RV_ST_FETCH;
      end
      default: state_n = `RV_ST_FETCH;
    endcase
  end

  // Strobes raised with the state change and dropped the cycle after ack
  assign bus_next = ((state_n == `RV_ST_FETCH) || (state_n == `RV_ST_MEM)) &&
                    !(wb_cyc && wb_ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= `RV_ST_FETCH;
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      state  <= state_n;
      wb_cyc <= bus_next;
      wb_we  <= bus_next && (state_n == `RV_ST_MEM) && is_store;
    end
  end

  assign wb_stb = wb_cyc;

endmodule

//--- logic/rv_datapath.sv
// Word-aligned bus addresses are assumed and JALR targets have bit 0 cleared
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_datapath (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pc_write,
  input  logic                    ir_write,
  input  logic                    mdr_write,
  input  logic                    reg_write,
  input  logic                    a_b_write,
  input  logic                    alu_out_write,
  input  logic [`RV_PC_SRC_W-1:0] pc_src,
  input  logic                    alu_src_a,
  input  logic                    alu_src_b,
  input  logic                    wb_sel_mem,
  input  logic                    wb_sel_pc4,
  input  logic                    adr_sel_data,
  input  logic [`RV_ALUOP_W-1:0]  alu_op_class,
  input  logic [31:0]             wb_rdata,
  output rv_pkg::instr_t          instr,
  output logic                    alu_bcond,
  output logic [31:0]             wb_adr,
  output logic [31:0]             wb_wdata
);

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;
  logic [31:0] mdr;
  logic [31:0] a_q;
  logic [31:0] b_q;
  logic [31:0] alu_out;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm;
  logic [31:0] alu_in_1;
  logic [31:0] alu_in_2;
  logic [31:0] alu_result;
  logic [31:0] rd_data;
  logic [`RV_ALU_W-1:0] alu_op;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (pc_src)
      `RV_PC_SRC_ALUOUT: pc_next = alu_out;
      `RV_PC_SRC_JUMP:   pc_next = {alu_result[31:1], 1'b0};
      default:           pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (pc_write) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr <= wb_rdata;
    end
    if (mdr_write) begin
      mdr <= wb_rdata;
    end
    if (a_b_write) begin
      a_q <= rs1_data;
      b_q <= rs2_data;
    end
    if (alu_out_write) begin
      alu_out <= wb_sel_pc4 ? pc_plus4 : alu_result;  // PC is still the jump's own address
    end
  end

  assign alu_in_1 = alu_src_a ? pc : a_q;
  assign alu_in_2 = alu_src_b ? imm : b_q;
  assign rd_data  = wb_sel_mem ? mdr : alu_out;
  assign wb_adr   = adr_sel_data ? alu_out : pc;
  assign wb_wdata = b_q;

  rv_regfile i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (instr.r.rs1),
    .rs2      (instr.r.rs2),
    .rd       (instr.r.rd),
    .reg_write(reg_write),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_imm_gen i_imm_gen (
    .instr(instr),
    .imm  (imm)
  );

  rv_alu_ctrl i_alu_ctrl (
    .instr       (instr),
    .alu_op_class(alu_op_class),
    .alu_op      (alu_op)
  );

  rv_alu i_alu (
    .alu_op    (alu_op),
    .alu_in_1  (alu_in_1),
    .alu_in_2  (alu_in_2),
    .funct3    (instr.r.funct3),
    .alu_result(alu_result),
    .alu_bcond (alu_bcond)
  );

endmodule

//--- logic/rv_imm_gen.sv
// Sign-extended immediates for I S B and J formats and zero for every other opcode
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_imm_gen (
  input  rv_pkg::instr_t instr,
  output logic [31:0]    imm
);

  always_comb begin
    case (instr.r.opcode)
      `RV_OP_ARITH_IMM, `RV_OP_LOAD, `RV_OP_JALR: begin
        imm = {{20{instr.i.imm[11]}}, instr.i.imm};
      end
      `RV_OP_STORE: begin
        imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      `RV_OP_BRANCH: begin
        // Halfword offset so bit 0 is always clear
        imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      `RV_OP_JAL: begin
        imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = 32'd0;
      end
    endcase
  end

endmodule

//--- logic/rv_pkg.sv
// Instruction word views for the R I S B and J formats only and no U format view
package rv_pkg;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

//--- logic/rv_regfile.sv
// Reads are combinational so the read address must be stable before A and B are captured
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        reg_write,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= 32'd0;
      end
    end else if (reg_write && (rd != 5'd0)) begin  // x0 stays zero
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- src.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_imm_gen.sv
logic/rv_alu_ctrl.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_ctrl_fsm.sv
logic/rv_datapath.sv
logic/rv_core.sv
verification/tb_wb_mem.sv
verification/tb_rv_core.sv

//--- verification/tb_rv_core.sv
// Program starts at word 0 and every store must land in order in the data window from 0x200
`timescale 1ns/1ps

module tb_rv_core;

  localparam int CLK_PERIOD       = 4;
  localparam int RESET_CYCLES     = 10;
  localparam int NUM_STORES       = 17;
  localparam int MAX_INSTR_CYCLES = 14;  // Load with three wait states on both accesses

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_wdata;
  logic [31:0] wb_rdata;
  logic        wb_ack;
  logic [31:0] prog [$];
  int          store_idx   = 0;
  int          reset_edges = 0;
  logic        first_seen  = 1'b0;

  // Address in the upper half and data in the lower half
  logic [63:0] exp_stores [NUM_STORES] = '{
    {32'h200, 32'h0000_0005}, {32'h204, 32'hffff_ffed},  // ADD and SUB
    {32'h208, 32'h0000_0060}, {32'h20c, 32'h1fff_ffff},  // SLL and SRL by 35
    {32'h210, 32'hffff_fff5}, {32'h214, 32'hffff_fffd},  // XOR and OR
    {32'h218, 32'h0000_0008}, {32'h21c, 32'hffff_fff3},  // AND and XORI
    {32'h220, 32'h0000_070d}, {32'h224, 32'h0000_00f0},  // ORI and ANDI
    {32'h228, 32'hffff_ff90}, {32'h22c, 32'h0000_000f},  // SLLI and SRLI
    {32'h230, 32'hffff_ffed}, {32'h234, 32'h0000_0000},  // LW copy and x0
    {32'h238, 32'h0000_00aa}, {32'h23c, 32'h0000_00c8},  // Branch mask and JAL link
    {32'h240, 32'h0000_00d8}                             // JALR link
  };

  function automatic logic [31:0] reg_op(input int f7, f3, rd, rs1, rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_op(input int f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] load_word(input int rd, rs1, imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(input int rs2, rs1, imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_if(input int f3, rs1, rs2, imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_to(input int rd, imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr_to(input int rd, rs1, imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction

  task automatic build_program();
    prog.push_back(imm_op(0, 10, 0, 'h200));    // x10 data base
    prog.push_back(imm_op(0, 1, 0, -7));
    prog.push_back(imm_op(0, 2, 0, 12));
    prog.push_back(imm_op(0, 5, 0, 35));        // Shifts by 35 act as 3
    prog.push_back(reg_op(0, 0, 3, 1, 2));      // 0x10 add
    prog.push_back(store_word(3, 10, 0));
    prog.push_back(reg_op('h20, 0, 4, 1, 2));   // sub
    prog.push_back(store_word(4, 10, 4));
    prog.push_back(reg_op(0, 1, 6, 2, 5));
    prog.push_back(store_word(6, 10, 8));
    prog.push_back(reg_op(0, 5, 7, 1, 5));
    prog.push_back(store_word(7, 10, 12));
    prog.push_back(reg_op(0, 4, 8, 1, 2));      // 0x30 xor
    prog.push_back(store_word(8, 10, 16));
    prog.push_back(reg_op(0, 6, 9, 1, 2));
    prog.push_back(store_word(9, 10, 20));
    prog.push_back(reg_op(0, 7, 11, 1, 2));
    prog.push_back(store_word(11, 10, 24));
    prog.push_back(imm_op(4, 12, 2, -1));       // 0x48 xori
    prog.push_back(store_word(12, 10, 28));
    prog.push_back(imm_op(6, 13, 2, 'h701));
    prog.push_back(store_word(13, 10, 32));
    prog.push_back(imm_op(7, 14, 1, 'hf0));
    prog.push_back(store_word(14, 10, 36));
    prog.push_back(imm_op(1, 15, 1, 4));        // slli
    prog.push_back(store_word(15, 10, 40));
    prog.push_back(imm_op(5, 16, 1, 28));       // srli
    prog.push_back(store_word(16, 10, 44));
    prog.push_back(load_word(17, 10, 4));       // 0x70 reads back the SUB result
    prog.push_back(store_word(17, 10, 48));
    prog.push_back(imm_op(0, 0, 0, 99));
    prog.push_back(store_word(0, 10, 52));
    // A taken branch skips its ORI so x18 collects the not-taken cases
    prog.push_back(branch_if(0, 3, 3, 8));      // 0x80 beq taken
    prog.push_back(imm_op(6, 18, 18, 'h01));
    prog.push_back(branch_if(0, 1, 2, 8));
    prog.push_back(imm_op(6, 18, 18, 'h02));
    prog.push_back(branch_if(1, 1, 2, 8));      // bne taken
    prog.push_back(imm_op(6, 18, 18, 'h04));
    prog.push_back(branch_if(1, 2, 2, 8));
    prog.push_back(imm_op(6, 18, 18, 'h08));
    prog.push_back(branch_if(4, 1, 2, 8));      // blt -7 < 12 taken
    prog.push_back(imm_op(6, 18, 18, 'h10));
    prog.push_back(branch_if(4, 2, 1, 8));
    prog.push_back(imm_op(6, 18, 18, 'h20));
    prog.push_back(branch_if(5, 2, 1, 8));      // bge 12 >= -7 taken
    prog.push_back(imm_op(6, 18, 18, 'h40));
    prog.push_back(branch_if(5, 1, 2, 8));
    prog.push_back(imm_op(6, 18, 18, 'h80));
    prog.push_back(store_word(18, 10, 56));     // 0xc0
    prog.push_back(jal_to(19, 8));              // 0xc4 links 0xc8
    prog.push_back(imm_op(0, 19, 0, 0));        // Skipped
    prog.push_back(store_word(19, 10, 60));
    prog.push_back(imm_op(0, 21, 0, 'hdc));
    prog.push_back(jalr_to(20, 21, 4));         // 0xd4 to 0xe0 and links 0xd8
    prog.push_back(imm_op(0, 20, 0, 0));
    prog.push_back(imm_op(0, 20, 0, 0));
    prog.push_back(store_word(20, 10, 64));     // 0xe0
    prog.push_back(jal_to(0, 0));               // Parks the core
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "Stopped on the first mismatch");
    end
  endtask

  rv_core i_dut (
    .clk     (clk),
    .reset   (reset),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_wdata(wb_wdata),
    .wb_rdata(wb_rdata),
    .wb_ack  (wb_ack)
  );

  tb_wb_mem i_mem (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_wdata(wb_wdata), .wb_rdata(wb_rdata), .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    @(negedge clk);
    build_program();
    for (int k = 0; k < prog.size(); k++) begin
      i_mem.mem[k] = prog[k];
    end
    repeat (RESET_CYCLES - 1) @(negedge clk);
    reset = 1'b0;
    wait (store_idx == NUM_STORES);
    @(negedge clk);
    $display("Finished with no errors");
    $finish;
  end

  // Bus monitor
  always @(posedge clk) begin
    if (reset) begin
      if (reset_edges > 0) begin  // Outputs are unknown before the first reset edge
        check_value("wb_cyc", {31'd0, wb_cyc}, 32'd0);
        check_value("wb_stb", {31'd0, wb_stb}, 32'd0);
      end
      reset_edges = reset_edges + 1;
    end else begin
      if (wb_stb && !first_seen) begin
        first_seen = 1'b1;
        check_value("wb_cyc", {31'd0, wb_cyc}, 32'd1);
        check_value("wb_adr", wb_adr, 32'd0);
        check_value("wb_we", {31'd0, wb_we}, 32'd0);
      end
      if (wb_cyc && wb_stb && wb_we && wb_ack && (store_idx < NUM_STORES)) begin
        check_value("wb_adr", wb_adr, exp_stores[store_idx][63:32]);
        check_value("wb_wdata", wb_wdata, exp_stores[store_idx][31:0]);
        store_idx = store_idx + 1;
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_STORES * 40 * MAX_INSTR_CYCLES));
    $display("Timeout with %0d of %0d stores seen on the bus", store_idx, NUM_STORES);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- verification/tb_wb_mem.sv
// Word memory of 1 KiB that ignores address bits above 9 and answers after 0 to 3 wait states
`timescale 1ns/1ps

module tb_wb_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  input  logic [31:0] wb_wdata,
  output logic [31:0] wb_rdata,
  output logic        wb_ack
);

  logic [31:0] mem [256];
  integer      seed       = 32'h1a83df95;
  logic        in_access  = 1'b0;
  int          waits_left = 0;

  initial begin
    wb_rdata = 32'd0;
    wb_ack   = 1'b0;
    for (int k = 0; k < 256; k++) begin
      mem[k] = 32'hbad0_0000 | (k * 4);  // Byte address shows through unwritten words
    end
  end

  // Responses change on the falling edge and the core samples them on the next rising edge
  always @(negedge clk) begin
    if (reset) begin
      wb_ack    <= 1'b0;
      in_access = 1'b0;
    end else if (wb_ack) begin
      wb_ack    <= 1'b0;  // Single-cycle ack
      in_access = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_access) begin
        in_access  = 1'b1;
        waits_left = $random(seed) & 3;
      end
      if (waits_left == 0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[wb_adr[9:2]] = wb_wdata;
        end else begin
          wb_rdata <= mem[wb_adr[9:2]];
        end
      end else begin
        waits_left = waits_left - 1;
      end
    end
  end

endmodule
